// File: rv_core.f
+incdir+design
+incdir+tb
design/rv_pkg.sv
design/rv_ctrl_if.sv
design/rv_word_ram.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_decoder.sv
design/rv_fetch.sv
design/rv_host_port.sv
design/rv_core.sv
tb/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f rv_core.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: tb/rv_host_tasks.svh
`ifndef RV_HOST_TASKS_SVH
`define RV_HOST_TASKS_SVH

// Runs one APB transfer and samples the response at the falling edge
task automatic apb_transfer(input apb_addr_t addr, input logic write, input word_t wdata,
                            output word_t rdata, output logic err);
    int waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (pready !== 1'b1) begin
        if (waited == APB_TIMEOUT) begin
            $display("Timeout: pready stayed low at address %h", addr);
            -> stall_ev;
        end
        @(negedge clk);
        waited++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic check_err(input apb_addr_t addr, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s: pslverr at %h expected %b actual %b",
                 cur_test, addr, expected, actual);
    end
endtask

task automatic apb_write(input apb_addr_t addr, input word_t data, input logic expect_err);
    word_t unused;
    logic  err;
    apb_transfer(addr, 1'b1, data, unused, err);
    check_err(addr, expect_err, err);
endtask

task automatic apb_read(input apb_addr_t addr, output word_t data, input logic expect_err);
    logic err;
    apb_transfer(addr, 1'b0, '0, data, err);
    check_err(addr, expect_err, err);
endtask

// RV32I encoders with fields in spec order
function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OP_R};
endfunction

function automatic word_t enc_i(input logic [6:0] op, input int rd, input logic [2:0] f3,
                                input int rs1, input logic [11:0] imm);
    return {imm, rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic word_t enc_s(input int rs2, input int rs1, input logic [11:0] imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_STORE};
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                input logic [12:0] off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `OP_BRANCH};
endfunction

function automatic word_t enc_u(input logic [6:0] op, input int rd, input logic [19:0] imm);
    return {imm, rd[4:0], op};
endfunction

// LUI plus ADDI for any 32-bit constant
task automatic emit_li(input int rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;   // Undo the sign of the low part
    prog.push_back(enc_u(`OP_LUI, rd, upper[31:12]));
    prog.push_back(enc_i(`OP_I, rd, 3'b000, rd, value[11:0]));
endtask

// Copies the queued program into IMEM from word 0
task automatic load_program();
    foreach (prog[i]) begin
        apb_write(`IMEM_BASE + apb_addr_t'(4 * i), prog[i], 1'b0);
    end
    prog.delete();
endtask

`endif

// File: tb/tb_rv_core.sv
`include "rv_defs.svh"

module tb_rv_core import rv_pkg::*; ();

    localparam int RUN_TIMEOUT = 2000;
    localparam int APB_TIMEOUT = 16;

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    int        seed = 98753;
    int        error_count;
    int        check_count;
    int        errors_at_start;
    string     cur_test;
    word_t     prog[$];     // Program being assembled
    event      stall_ev;

    rv_core UUT (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #20 clk = ~clk;

    `include "rv_host_tasks.svh"

    // Ends the run when a wait loop gives up
    initial begin
        @(stall_ev);
        $display("TEST FAILED");
        $finish;
    end

    task automatic compare_word(input string what, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: %s expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        int errs;
        errs = error_count - errors_at_start;
        if (errs == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d mismatches", cur_test, errs);
        end
    endtask

    task automatic check_reg(input int n, input word_t expected);
        word_t data;
        apb_read(`REG_BASE + apb_addr_t'(4 * n), data, 1'b0);
        compare_word($sformatf("x%0d", n), expected, data);
    endtask

    task automatic check_dmem(input int idx, input word_t expected);
        word_t data;
        apb_read(`DMEM_BASE + apb_addr_t'(4 * idx), data, 1'b0);
        compare_word($sformatf("dmem[%0d]", idx), expected, data);
    endtask

    task automatic start_core();
        apb_write(`CTRL_ADDR, 32'h1, 1'b0);
    endtask

    // Polls the halted bit with one status read every three cycles
    task automatic wait_halt();
        word_t status;
        int    cycles;
        status = '0;
        cycles = 0;
        while (status[1] !== 1'b1) begin
            if (cycles >= RUN_TIMEOUT) begin
                $display("Timeout: core did not halt within %0d cycles", RUN_TIMEOUT);
                -> stall_ev;
                @(posedge clk);
            end
            apb_read(`CTRL_ADDR, status, 1'b0);
            cycles += 3;
        end
    endtask

    task automatic run_program();
        load_program();
        start_core();
        wait_halt();
    endtask

    task automatic test_apb_map();
        word_t     data;
        word_t     values[4];
        apb_addr_t offs;
        begin_test("apb_map");
        apb_read(`CTRL_ADDR, data, 1'b0);
        compare_word("status after reset", 32'h0, data);
        for (int i = 0; i < 4; i++) begin
            values[i] = $random(seed);
            offs      = apb_addr_t'(4 * (i * 61 + 7));
            apb_write(`IMEM_BASE + offs, values[i], 1'b0);
            apb_write(`DMEM_BASE + offs, values[i] ^ 32'h5a5a_5a5a, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            offs = apb_addr_t'(4 * (i * 61 + 7));
            apb_read(`IMEM_BASE + offs, data, 1'b0);
            compare_word("imem readback", values[i], data);
            apb_read(`DMEM_BASE + offs, data, 1'b0);
            compare_word("dmem readback", values[i] ^ 32'h5a5a_5a5a, data);
        end
        apb_read(16'h4000, data, 1'b1);    // Unmapped
        apb_write(16'h0104, 32'h1, 1'b1);
        prog.push_back(enc_b(3'b000, 0, 0, 13'd0));   // Self loop
        load_program();
        start_core();
        apb_read(`CTRL_ADDR, data, 1'b0);
        compare_word("status while running", 32'h1, data);
        apb_read(`DMEM_BASE, data, 1'b1);
        apb_read(`REG_BASE + 16'd4, data, 1'b1);
        apb_write(`IMEM_BASE, 32'h0, 1'b1);
        apb_write(`CTRL_ADDR, 32'h0, 1'b0);
        apb_read(`CTRL_ADDR, data, 1'b0);
        compare_word("status after stop", 32'h0, data);
        end_test();
    endtask

    task automatic test_arith();
        word_t       a;
        word_t       b;
        word_t       ie;
        logic [11:0] imm;
        begin_test("arith_logic");
        a       = $random(seed);
        b       = $random(seed);
        b[31]   = ~a[31];    // Opposite signs so SLT and SLTU differ
        imm     = 12'($random(seed));
        imm[11] = a[31];     // Same sign so SLTI depends on magnitude
        ie      = {{20{imm[11]}}, imm};
        emit_li(1, a);
        emit_li(2, b);
        prog.push_back(enc_r(7'h00, 2, 1, 3'b000, 3));   // ADD
        prog.push_back(enc_r(7'h20, 2, 1, 3'b000, 4));   // SUB
        prog.push_back(enc_r(7'h00, 2, 1, 3'b111, 5));
        prog.push_back(enc_r(7'h00, 2, 1, 3'b110, 6));
        prog.push_back(enc_r(7'h00, 2, 1, 3'b100, 7));
        prog.push_back(enc_r(7'h00, 2, 1, 3'b010, 8));   // SLT
        prog.push_back(enc_r(7'h00, 2, 1, 3'b011, 9));
        prog.push_back(enc_r(7'h00, 1, 2, 3'b010, 16));  // Operands swapped
        prog.push_back(enc_r(7'h00, 1, 2, 3'b011, 17));
        prog.push_back(enc_i(`OP_I, 10, 3'b000, 1, imm));
        prog.push_back(enc_i(`OP_I, 11, 3'b111, 1, imm));
        prog.push_back(enc_i(`OP_I, 12, 3'b110, 1, imm));
        prog.push_back(enc_i(`OP_I, 13, 3'b100, 1, imm));
        prog.push_back(enc_i(`OP_I, 14, 3'b010, 1, imm));
        prog.push_back(enc_i(`OP_I, 15, 3'b011, 1, imm));
        prog.push_back(enc_i(`OP_I, 0, 3'b000, 1, imm));  // x0 stays zero
        prog.push_back(`HALT_INSN);
        run_program();
        check_reg(1, a);
        check_reg(2, b);
        check_reg(3, a + b);
        check_reg(4, a - b);
        check_reg(5, a & b);
        check_reg(6, a | b);
        check_reg(7, a ^ b);
        check_reg(8, word_t'($signed(a) < $signed(b)));
        check_reg(9, word_t'(a < b));
        check_reg(16, word_t'($signed(b) < $signed(a)));
        check_reg(17, word_t'(b < a));
        check_reg(10, a + ie);
        check_reg(11, a & ie);
        check_reg(12, a | ie);
        check_reg(13, a ^ ie);
        check_reg(14, word_t'($signed(a) < $signed(ie)));
        check_reg(15, word_t'(a < ie));
        check_reg(0, 32'h0);
        end_test();
    endtask

    task automatic test_load_store();
        word_t d[4];
        begin_test("load_store");
        for (int i = 0; i < 4; i++) begin
            d[i] = $random(seed);
            apb_write(`DMEM_BASE + apb_addr_t'(4 * i), d[i], 1'b0);
        end
        prog.push_back(enc_i(`OP_LOAD, 1, 3'b010, 0, 12'd0));
        prog.push_back(enc_i(`OP_LOAD, 2, 3'b010, 0, 12'd4));
        prog.push_back(enc_i(`OP_LOAD, 3, 3'b010, 0, 12'd8));
        prog.push_back(enc_i(`OP_I, 10, 3'b000, 0, 12'd16));
        prog.push_back(enc_i(`OP_LOAD, 4, 3'b010, 10, -12'sd4));   // Negative offset
        prog.push_back(enc_r(7'h00, 2, 1, 3'b000, 5));
        prog.push_back(enc_r(7'h00, 4, 3, 3'b000, 6));
        prog.push_back(enc_s(5, 0, 12'd64));
        prog.push_back(enc_s(6, 10, 12'd4));
        prog.push_back(enc_s(1, 10, 12'd100));
        prog.push_back(`HALT_INSN);
        run_program();
        check_reg(1, d[0]);
        check_reg(2, d[1]);
        check_reg(3, d[2]);
        check_reg(4, d[3]);
        check_reg(5, d[0] + d[1]);
        check_reg(6, d[2] + d[3]);
        check_dmem(16, d[0] + d[1]);
        check_dmem(5, d[2] + d[3]);
        check_dmem(29, d[0]);
        for (int i = 0; i < 4; i++) begin
            check_dmem(i, d[i]);
        end
        end_test();
    endtask

    task automatic test_branches();
        begin_test("branches");
        prog.push_back(enc_i(`OP_I, 1, 3'b000, 0, 12'd5));
        prog.push_back(enc_i(`OP_I, 2, 3'b000, 0, 12'd5));
        prog.push_back(enc_i(`OP_I, 3, 3'b000, 0, 12'd7));
        prog.push_back(enc_i(`OP_I, 10, 3'b000, 0, 12'h055));   // Marker start values
        prog.push_back(enc_i(`OP_I, 11, 3'b000, 0, 12'h066));
        prog.push_back(enc_i(`OP_I, 16, 3'b000, 0, 12'd0));
        prog.push_back(enc_i(`OP_I, 15, 3'b000, 0, 12'd3));
        prog.push_back(enc_b(3'b000, 1, 2, 13'd8));    // BEQ taken
        prog.push_back(enc_i(`OP_I, 10, 3'b000, 0, 12'd1));
        prog.push_back(enc_b(3'b001, 1, 3, 13'd8));    // BNE taken
        prog.push_back(enc_i(`OP_I, 11, 3'b000, 0, 12'd1));
        prog.push_back(enc_b(3'b000, 1, 3, 13'd8));    // BEQ not taken
        prog.push_back(enc_i(`OP_I, 12, 3'b000, 0, 12'h012));
        prog.push_back(enc_b(3'b001, 1, 2, 13'd8));    // BNE not taken
        prog.push_back(enc_i(`OP_I, 13, 3'b000, 0, 12'h013));
        prog.push_back(enc_i(`OP_I, 15, 3'b000, 15, -12'sd1));
        prog.push_back(enc_i(`OP_I, 16, 3'b000, 16, 12'd1));
        prog.push_back(enc_b(3'b001, 15, 0, -13'sd8)); // Loop back three times
        prog.push_back(`HALT_INSN);
        run_program();
        check_reg(10, 32'h55);
        check_reg(11, 32'h66);
        check_reg(12, 32'h12);
        check_reg(13, 32'h13);
        check_reg(15, 32'h0);
        check_reg(16, 32'd3);
        end_test();
    endtask

    task automatic test_upper();
        logic [19:0] up;
        begin_test("upper_imm");
        up = 20'($random(seed));
        prog.push_back(enc_u(`OP_LUI, 1, 20'hABCDE));
        prog.push_back(enc_u(`OP_AUIPC, 2, 20'h12345));   // PC 4
        prog.push_back(enc_i(`OP_I, 0, 3'b000, 0, 12'd0));
        prog.push_back(enc_u(`OP_AUIPC, 3, 20'hFFFFF));   // PC 12
        prog.push_back(enc_u(`OP_LUI, 4, up));
        prog.push_back(`HALT_INSN);
        run_program();
        check_reg(1, 32'hABCD_E000);
        check_reg(2, 32'd4 + 32'h1234_5000);
        check_reg(3, 32'd12 + 32'hFFFF_F000);
        check_reg(4, {up, 12'h000});
        end_test();
    endtask

    task automatic check_counter_results();
        check_reg(20, 32'd0);
        check_reg(21, 32'd30);
        check_dmem(32, 32'd30);
    endtask

    task automatic test_restart();
        word_t data;
        begin_test("restart");
        prog.push_back(enc_i(`OP_I, 20, 3'b000, 0, 12'd10));
        prog.push_back(enc_i(`OP_I, 21, 3'b000, 0, 12'd0));
        prog.push_back(enc_i(`OP_I, 21, 3'b000, 21, 12'd3));
        prog.push_back(enc_i(`OP_I, 20, 3'b000, 20, -12'sd1));
        prog.push_back(enc_b(3'b001, 20, 0, -13'sd8));
        prog.push_back(enc_s(21, 0, 12'd128));
        prog.push_back(`HALT_INSN);
        run_program();
        apb_read(`CTRL_ADDR, data, 1'b0);
        compare_word("status after halt", 32'h2, data);
        check_counter_results();
        apb_write(`DMEM_BASE + 16'd128, 32'h0, 1'b0);   // Clear the stored result
        start_core();
        apb_read(`CTRL_ADDR, data, 1'b0);
        compare_word("status after restart", 32'h1, data);
        wait_halt();
        check_counter_results();
        end_test();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        error_count = 0;
        check_count = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_apb_map();
        test_arith();
        test_load_store();
        test_branches();
        test_upper();
        test_restart();

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: design/rv_core.sv
`include "rv_defs.svh"

module rv_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr
);

    rv_ctrl_if ctrl ();

    logic       running;
    logic       start;
    logic       zero;
    word_t      insn;
    word_t      pc;
    imem_addr_t imem_index;

    // Host access path
    dmem_addr_t host_addr;
    word_t      host_wdata;
    logic       imem_host_we;
    logic       dmem_host_we;
    word_t      imem_host_rdata;
    word_t      dmem_host_rdata;
    word_t      reg_host_rdata;
    reg_addr_t  host_reg;

    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      rdata1;
    word_t      rdata2;
    word_t      alu_result;
    word_t      wb_data;
    word_t      dmem_rdata;

    rv_host_port u_host (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .running(running), .start(start), .insn(insn),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .imem_host_we(imem_host_we), .dmem_host_we(dmem_host_we),
        .imem_host_rdata(imem_host_rdata), .dmem_host_rdata(dmem_host_rdata),
        .reg_host_rdata(reg_host_rdata), .host_reg(host_reg)
    );

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .running(running), .start(start), .zero(zero),
        .ctrl(ctrl.consumer), .pc(pc), .imem_index(imem_index)
    );

    // Instruction memory, written by the host only
    rv_word_ram #(.DEPTH(`IMEM_WORDS)) u_imem (
        .clk(clk), .core_index(imem_index), .host_index(host_addr),
        .core_we(1'b0), .host_we(imem_host_we),
        .core_wdata('0), .host_wdata(host_wdata),
        .core_rdata(insn), .host_rdata(imem_host_rdata)
    );

    rv_decoder u_dec (
        .insn(insn), .running(running), .ctrl(ctrl.producer),
        .rs1(rs1), .rs2(rs2), .rd(rd)
    );

    rv_regfile u_regs (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd), .host_reg(host_reg),
        .wdata(wb_data), .ctrl(ctrl.consumer),
        .rdata1(rdata1), .rdata2(rdata2), .host_rdata(reg_host_rdata)
    );

    rv_alu u_alu (
        .ctrl(ctrl.consumer), .pc(pc), .rdata1(rdata1), .rdata2(rdata2),
        .mem_rdata(dmem_rdata), .result(alu_result), .wb_data(wb_data), .zero(zero)
    );

    // Data memory addressed by the ALU result
    rv_word_ram #(.DEPTH(`DMEM_WORDS)) u_dmem (
        .clk(clk), .core_index(alu_result[$bits(dmem_addr_t)+1:2]), .host_index(host_addr),
        .core_we(ctrl.mem_write), .host_we(dmem_host_we),
        .core_wdata(rdata2), .host_wdata(host_wdata),
        .core_rdata(dmem_rdata), .host_rdata(dmem_host_rdata)
    );

endmodule

// File: design/rv_host_port.sv
`include "rv_defs.svh"

module rv_host_port import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       running,
    output logic       start,
    input  word_t      insn,
    output dmem_addr_t host_addr,
    output word_t      host_wdata,
    output logic       imem_host_we,
    output logic       dmem_host_we,
    input  word_t      imem_host_rdata,
    input  word_t      dmem_host_rdata,
    input  word_t      reg_host_rdata,
    output reg_addr_t  host_reg
);

    run_state_e state;

    logic access;
    logic ctrl_hit;
    logic imem_hit;
    logic dmem_hit;
    logic reg_hit;
    logic mapped;
    logic busy;
    logic host_ok;
    logic ctrl_we;

    assign access = psel & penable;   // APB access phase

    // Address map decode
    assign ctrl_hit = (paddr == `CTRL_ADDR);
    assign imem_hit = (paddr >= `IMEM_BASE) && (paddr < `IMEM_BASE + 4 * `IMEM_WORDS);
    assign dmem_hit = (paddr >= `DMEM_BASE) && (paddr < `DMEM_BASE + 4 * `DMEM_WORDS);
    assign reg_hit  = (paddr >= `REG_BASE) && (paddr < `REG_BASE + 4 * `REG_COUNT);
    assign mapped   = ctrl_hit | imem_hit | dmem_hit | reg_hit;

    // Storage is owned by the core while it runs
    assign busy = running & (imem_hit | dmem_hit | reg_hit);

    assign pready  = 1'b1;    // No wait states
    assign pslverr = access & (~mapped | busy);
    assign host_ok = access & ~pslverr;

    assign ctrl_we      = host_ok & pwrite & ctrl_hit;
    assign start        = ctrl_we & pwdata[0];
    assign imem_host_we = host_ok & pwrite & imem_hit;
    assign dmem_host_we = host_ok & pwrite & dmem_hit;  // Register region is read only

    assign host_addr  = paddr[$bits(dmem_addr_t)+1:2];
    assign host_reg   = paddr[$bits(reg_addr_t)+1:2];
    assign host_wdata = pwdata;

    assign running = (state == RUN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (ctrl_we) begin
            state <= pwdata[0] ? RUN : IDLE;
        end else if (running && insn == `HALT_INSN) begin
            state <= HALTED;   // EBREAK fetched
        end
    end

    // Read data is driven only during a good read access
    always_comb begin
        prdata = '0;
        if (host_ok && !pwrite) begin
            if (ctrl_hit) begin
                prdata = {{(`XLEN-2){1'b0}}, state == HALTED, running};
            end else if (imem_hit) begin
                prdata = imem_host_rdata;
            end else if (dmem_hit) begin
                prdata = dmem_host_rdata;
            end else begin
                prdata = reg_host_rdata;
            end
        end
    end

endmodule

// File: design/rv_fetch.sv
`include "rv_defs.svh"

module rv_fetch import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               running,
    input  logic               start,
    input  logic               zero,
    rv_ctrl_if.consumer        ctrl,
    output word_t              pc,
    output imem_addr_t         imem_index
);

    word_t pc_plus_step;
    word_t pc_target;
    logic  taken;

    assign pc_plus_step = pc + `PC_STEP;
    assign pc_target    = pc + ctrl.imm;     // Branch target

    // BEQ taken on zero, BNE on nonzero
    assign taken = ctrl.branch & (zero ^ ctrl.branch_on_ne);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (start) begin
            pc <= `RESET_PC;
        end else if (running) begin
            pc <= taken ? pc_target : pc_plus_step;
        end
    end

    assign imem_index = pc[$bits(imem_addr_t)+1:2];   // Word index

endmodule

// File: design/rv_decoder.sv
`include "rv_defs.svh"

module rv_decoder import rv_pkg::*; (
    input  word_t              insn,
    input  logic               running,
    rv_ctrl_if.producer        ctrl,
    output reg_addr_t          rs1,
    output reg_addr_t          rs2,
    output reg_addr_t          rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;

    logic write_reg;
    logic write_mem;

    // Shift encodings are not implemented
    function automatic logic arith_legal(input logic [2:0] f3);
        return !(f3 == 3'b001 || f3 == 3'b101);
    endfunction

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? `ALU_SUB : `ALU_ADD;
            3'b010:  return `ALU_SLT;
            3'b011:  return `ALU_SLTU;
            3'b100:  return `ALU_XOR;
            3'b110:  return `ALU_OR;
            default: return `ALU_AND;
        endcase
    endfunction

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    assign rs1 = insn[19:15];
    assign rs2 = insn[24:20];
    assign rd  = insn[11:7];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};

    always_comb begin
        ctrl.alu_op       = `ALU_ADD;
        ctrl.opa_sel      = `OPA_RS1;
        ctrl.alu_src_imm  = 1'b0;
        ctrl.mem_to_reg   = 1'b0;
        ctrl.branch       = 1'b0;
        ctrl.branch_on_ne = 1'b0;
        ctrl.imm          = imm_i;
        write_reg         = 1'b0;
        write_mem         = 1'b0;
        case (opcode)
            `OP_R: begin
                ctrl.alu_op = arith_op(funct3, funct7[5]);
                // SUB is the only R-type with a nonzero funct7
                write_reg = arith_legal(funct3) &&
                            (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000));
            end
            `OP_I: begin
                ctrl.alu_op      = arith_op(funct3, 1'b0);
                ctrl.alu_src_imm = 1'b1;
                write_reg        = arith_legal(funct3);
            end
            `OP_LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                write_reg        = (funct3 == 3'b010);   // LW only
            end
            `OP_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_s;
                write_mem        = (funct3 == 3'b010);   // SW only
            end
            `OP_BRANCH: begin
                ctrl.alu_op       = `ALU_SUB;
                ctrl.imm          = imm_b;
                ctrl.branch       = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl.branch_on_ne = funct3[0];
            end
            `OP_LUI, `OP_AUIPC: begin
                ctrl.opa_sel     = (opcode == `OP_LUI) ? `OPA_ZERO : `OPA_PC;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_u;
                write_reg        = 1'b1;
            end
            default: begin
                // EBREAK and unknown opcodes leave state untouched
            end
        endcase
    end

    assign ctrl.reg_write = write_reg & running;
    assign ctrl.mem_write = write_mem & running;

endmodule

// File: design/rv_alu.sv
`include "rv_defs.svh"

module rv_alu import rv_pkg::*; (
    rv_ctrl_if.consumer        ctrl,
    input  word_t              pc,
    input  word_t              rdata1,
    input  word_t              rdata2,
    input  word_t              mem_rdata,
    output word_t              result,
    output word_t              wb_data,
    output logic               zero
);

    word_t op_a;
    word_t op_b;

    // Operand A is the PC for AUIPC and zero for LUI
    always_comb begin
        case (ctrl.opa_sel)
            `OPA_PC:   op_a = pc;
            `OPA_ZERO: op_a = '0;
            default:   op_a = rdata1;
        endcase
    end

    assign op_b = ctrl.alu_src_imm ? ctrl.imm : rdata2;

    always_comb begin
        case (ctrl.alu_op)
            `ALU_ADD:  result = op_a + op_b;
            `ALU_SUB:  result = op_a - op_b;
            `ALU_AND:  result = op_a & op_b;
            `ALU_OR:   result = op_a | op_b;
            `ALU_XOR:  result = op_a ^ op_b;
            `ALU_SLTU: result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            `ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:   result = '0;
        endcase
    end

    assign zero = (result == '0);   // Branch compare

    assign wb_data = ctrl.mem_to_reg ? mem_rdata : result;

endmodule

// File: design/rv_regfile.sv
`include "rv_defs.svh"

module rv_regfile import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  reg_addr_t          rs1,
    input  reg_addr_t          rs2,
    input  reg_addr_t          rd,
    input  reg_addr_t          host_reg,
    input  word_t              wdata,
    rv_ctrl_if.consumer        ctrl,
    output word_t              rdata1,
    output word_t              rdata2,
    output word_t              host_rdata
);

    word_t regs [`REG_COUNT];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1     = regs[rs1];
    assign rdata2     = regs[rs2];
    assign host_rdata = regs[host_reg];

endmodule

// File: design/rv_word_ram.sv
module rv_word_ram import rv_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] core_index,
    input  logic [$clog2(DEPTH)-1:0] host_index,
    input  logic                     core_we,
    input  logic                     host_we,
    input  word_t                    core_wdata,
    input  word_t                    host_wdata,
    output word_t                    core_rdata,
    output word_t                    host_rdata
);

    word_t mem [DEPTH];

    // Core and host never write in the same cycle
    always_ff @(posedge clk) begin
        if (core_we) begin
            mem[core_index] <= core_wdata;
        end
        if (host_we) begin
            mem[host_index] <= host_wdata;
        end
    end

    // Asynchronous reads on both ports
    assign core_rdata = mem[core_index];
    assign host_rdata = mem[host_index];

endmodule

// File: design/rv_ctrl_if.sv
// Decoded control bundle for the current instruction
interface rv_ctrl_if import rv_pkg::*; ();

    alu_op_t  alu_op;
    opa_sel_t opa_sel;
    logic     alu_src_imm;   // Operand B from imm instead of rs2
    logic     mem_write;
    logic     mem_to_reg;
    logic     reg_write;
    logic     branch;
    logic     branch_on_ne;  // BNE rather than BEQ
    word_t    imm;

    modport producer (
        output alu_op, opa_sel, alu_src_imm, mem_write, mem_to_reg,
        output reg_write, branch, branch_on_ne, imm
    );

    modport consumer (
        input alu_op, opa_sel, alu_src_imm, mem_write, mem_to_reg,
        input reg_write, branch, branch_on_ne, imm
    );

endinterface

// File: design/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

    typedef logic [3:0] alu_op_t;
    typedef logic [1:0] opa_sel_t;     // PC, zero or rs1

    // Word indices into the two memories
    typedef logic [$clog2(`IMEM_WORDS)-1:0] imem_addr_t;
    typedef logic [$clog2(`DMEM_WORDS)-1:0] dmem_addr_t;

    typedef logic [15:0] apb_addr_t;

    // Host-visible run state
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HALTED
    } run_state_e;

endpackage

// File: design/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath and storage sizes
`define XLEN        32
`define REG_COUNT   32
`define IMEM_WORDS  256
`define DMEM_WORDS  256

`define PC_STEP     32'd4
`define RESET_PC    32'd0
`define HALT_INSN   32'h0010_0073   // EBREAK

// APB address map in byte addresses
`define CTRL_ADDR   16'h0000
`define IMEM_BASE   16'h1000
`define DMEM_BASE   16'h2000
`define REG_BASE    16'h3000

// ALU operation codes
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLTU    4'd9
`define ALU_SLT     4'd10

// Operand A sources
`define OPA_PC      2'd0
`define OPA_ZERO    2'd1
`define OPA_RS1     2'd2

// Major opcodes
`define OP_R        7'b0110011
`define OP_I        7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_SYSTEM   7'b1110011

`endif
